// File: pipe_trace.f
src/pipe_pkg.sv
src/wb_host_regs.sv
src/fetch_stage.sv
src/exec_core.sv
src/trace_unit.sv
src/pipe_trace_top.sv
tb/pipe_trace_checker.sv
tb/pipe_trace_tb.sv

// File: src/exec_core.sv
`timescale 1ns/1ps

module exec_core (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         fetch_fire,
    input  logic [pipe_pkg::INSTR_W-1:0] fetch_instr,
    output logic [pipe_pkg::DATA_W-1:0]  wb_result
);
    import pipe_pkg::*;

    // general registers, r0 included
    logic [DATA_W-1:0] rf [NUM_REGS];

    // decode
    logic              v_d;
    opcode_t           op_d;
    logic [REG_W-1:0]  rd_d;
    logic [REG_W-1:0]  rs1_d;
    logic [REG_W-1:0]  rs2_d;
    logic [DATA_W-1:0] imm_d;
    logic              we_d;
    logic [DATA_W-1:0] opa_d;
    logic [DATA_W-1:0] opb_d;

    // execute
    logic              v_e;
    opcode_t           op_e;
    logic [REG_W-1:0]  rd_e;
    logic              we_e;
    logic [DATA_W-1:0] opa_e;
    logic [DATA_W-1:0] opb_e;
    logic [DATA_W-1:0] imm_e;
    logic [DATA_W-1:0] alu_e;

    // memory, timing only
    logic              v_m;
    logic [REG_W-1:0]  rd_m;
    logic              we_m;
    logic [DATA_W-1:0] res_m;

    // writeback
    logic              v_w;
    logic [REG_W-1:0]  rd_w;
    logic              we_w;
    logic [DATA_W-1:0] res_w;

    ////////////////////
    // decode
    ////////////////////

    assign op_d  = opcode_t'(fetch_instr[OPC_LSB +: OPC_W]);
    assign rd_d  = fetch_instr[RD_LSB +: REG_W];
    assign rs1_d = fetch_instr[RS1_LSB +: REG_W];
    assign rs2_d = fetch_instr[RS2_LSB +: REG_W];
    assign imm_d = DATA_W'(fetch_instr[IMM_W-1:0]);
    // undefined codes write nothing, like nop
    assign we_d  = op_d inside {OP_LDI, OP_ADD, OP_SUB, OP_AND, OP_XOR};

    // operand lookup, youngest producer wins
    // the writeback hit is the bypass of this cycle's register file write
    function automatic logic [DATA_W-1:0] fwd(input logic [REG_W-1:0] rs);
        logic [DATA_W-1:0] val;
        if (v_e && we_e && rd_e == rs) begin
            val = alu_e;
        end else if (v_m && we_m && rd_m == rs) begin
            val = res_m;
        end else if (v_w && we_w && rd_w == rs) begin
            val = res_w;
        end else begin
            val = rf[rs];
        end
        return val;
    endfunction

    always_comb begin
        opa_d = fwd(rs1_d);
        opb_d = fwd(rs2_d);
    end

    ////////////////////
    // execute
    ////////////////////

    // 16 bit wraparound on add and sub
    always_comb begin
        case (op_e)
            OP_LDI:  alu_e = imm_e;
            OP_ADD:  alu_e = opa_e + opb_e;
            OP_SUB:  alu_e = opa_e - opb_e;
            OP_AND:  alu_e = opa_e & opb_e;
            OP_XOR:  alu_e = opa_e ^ opb_e;
            default: alu_e = '0;
        endcase
    end

    ////////////////////
    // pipeline registers
    ////////////////////

    // valid bits, a bubble enters whenever fetch does not fire
    always_ff @(posedge clk) begin
        if (rst) begin
            v_d <= 1'b0;
            v_e <= 1'b0;
            v_m <= 1'b0;
            v_w <= 1'b0;
        end else begin
            v_d <= fetch_fire;
            v_e <= v_d;
            v_m <= v_e;
            v_w <= v_m;
        end
    end

    // payload follows its valid bit
    always_ff @(posedge clk) begin
        op_e  <= op_d;
        rd_e  <= rd_d;
        we_e  <= we_d;
        opa_e <= opa_d;
        opb_e <= opb_d;
        imm_e <= imm_d;
        rd_m  <= rd_e;
        we_m  <= we_e;
        res_m <= alu_e;
        rd_w  <= rd_m;
        we_w  <= we_m;
        res_w <= res_m;
    end

    // register file write at the end of writeback
    always_ff @(posedge clk) begin
        if (v_w && we_w) begin
            rf[rd_w] <= res_w;
        end
    end

    // retiring result, 0 for a bubble
    assign wb_result = v_w ? res_w : '0;

endmodule

// File: src/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         run,
    input  logic                         hold,
    input  logic                         imem_we,
    input  logic [pipe_pkg::IDX_W-1:0]   imem_waddr,
    input  logic [pipe_pkg::INSTR_W-1:0] imem_wdata,
    output logic                         fetch_fire,
    output logic [pipe_pkg::INSTR_W-1:0] fetch_instr,
    output logic                         halted
);
    import pipe_pkg::*;

    // memory index width, and a pc that can also reach IMEM_DEPTH itself
    localparam int AW   = $clog2(IMEM_DEPTH);
    localparam int PC_W = $clog2(IMEM_DEPTH + 1);

    logic [INSTR_W-1:0] imem [IMEM_DEPTH];
    logic [PC_W-1:0]    pc;
    logic [INSTR_W-1:0] cur_word;

    // host writes, addresses past the depth are dropped
    always_ff @(posedge clk) begin
        if (imem_we && 32'(imem_waddr) < IMEM_DEPTH) begin
            imem[imem_waddr[AW-1:0]] <= imem_wdata;
        end
    end

    assign cur_word = imem[pc[AW-1:0]];

    // issue while running, not held, not halted and still inside the program
    assign fetch_fire = run && !hold && !halted && (32'(pc) < IMEM_DEPTH);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc     <= '0;
            halted <= 1'b0;
        end else if (!run) begin
            // stopped, so the next start begins at word 0
            pc     <= '0;
            halted <= 1'b0;
        end else if (fetch_fire) begin
            pc <= pc + 1'b1;
            // halt is the last word issued
            if (cur_word[OPC_LSB +: OPC_W] == OP_HALT) begin
                halted <= 1'b1;
            end
        end
    end

    // fetched word, consumed by decode in the next cycle
    always_ff @(posedge clk) begin
        if (fetch_fire) begin
            fetch_instr <= cur_word;
        end
    end

endmodule

// File: src/pipe_pkg.sv
package pipe_pkg;

    ////////////////////
    // datapath widths
    ////////////////////

    localparam int DATA_W   = 16;
    localparam int INSTR_W  = 16;
    localparam int NUM_REGS = 8;
    localparam int REG_W    = $clog2(NUM_REGS);
    // trace cycle stamps, two of them fill one bus word
    localparam int CYC_W    = 16;

    // instruction fields: opcode, rd, rs1, rs2 from the top down
    localparam int OPC_W   = 4;
    localparam int OPC_LSB = 12;
    localparam int RD_LSB  = 9;
    localparam int RS1_LSB = 6;
    localparam int RS2_LSB = 3;
    // ldi immediate in the low byte, zero extended
    localparam int IMM_W   = 8;

    typedef enum logic [OPC_W-1:0] {
        OP_NOP  = 4'h0,
        OP_LDI  = 4'h1,
        OP_ADD  = 4'h2,
        OP_SUB  = 4'h3,
        OP_AND  = 4'h4,
        OP_XOR  = 4'h5,
        OP_HALT = 4'hf
    } opcode_t;

    ////////////////////
    // host address map
    ////////////////////

    // word addresses, the low IDX_W bits index inside a region
    localparam int ADR_W = 9;
    localparam int IDX_W = 6;

    localparam logic [ADR_W-1:0] ADR_IMEM_BASE      = 9'h000;
    localparam logic [ADR_W-1:0] ADR_CTRL           = 9'h040;
    localparam logic [ADR_W-1:0] ADR_STATUS         = 9'h041;
    localparam logic [ADR_W-1:0] ADR_TRACE_CYC_BASE = 9'h080;
    localparam logic [ADR_W-1:0] ADR_TRACE_RES_BASE = 9'h0c0;

endpackage

// File: src/pipe_trace_top.sv
`timescale 1ns/1ps

module pipe_trace_top #(
    parameter int IMEM_DEPTH  = 64,
    parameter int TRACE_DEPTH = 64
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       wb_cyc,
    input  logic                       wb_stb,
    input  logic                       wb_we,
    input  logic [pipe_pkg::ADR_W-1:0] wb_adr,
    input  logic [31:0]                wb_dat_w,
    output logic [31:0]                wb_dat_r,
    output logic                       wb_ack
);
    import pipe_pkg::*;

    // host side
    logic               imem_we;
    logic [IDX_W-1:0]   imem_waddr;
    logic [INSTR_W-1:0] imem_wdata;
    logic               run;
    logic               hold;
    logic [IDX_W-1:0]   trace_idx;

    // pipeline and tracker
    logic               fetch_fire;
    logic [INSTR_W-1:0] fetch_instr;
    logic               halted;
    logic [DATA_W-1:0]  wb_result;
    logic [CYC_W-1:0]   trace_fetch_cyc;
    logic [CYC_W-1:0]   trace_retire_cyc;
    logic [DATA_W-1:0]  trace_result;
    logic [7:0]         retired_count;

    wb_host_regs wb_host_regs_i (
        .clk              (clk),
        .rst              (rst),
        .wb_cyc           (wb_cyc),
        .wb_stb           (wb_stb),
        .wb_we            (wb_we),
        .wb_adr           (wb_adr),
        .wb_dat_w         (wb_dat_w),
        .wb_dat_r         (wb_dat_r),
        .wb_ack           (wb_ack),
        .halted           (halted),
        .retired_count    (retired_count),
        .trace_fetch_cyc  (trace_fetch_cyc),
        .trace_retire_cyc (trace_retire_cyc),
        .trace_result     (trace_result),
        .imem_we          (imem_we),
        .imem_waddr       (imem_waddr),
        .imem_wdata       (imem_wdata),
        .run              (run),
        .hold             (hold),
        .trace_idx        (trace_idx)
    );

    fetch_stage #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) fetch_stage_i (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .hold        (hold),
        .imem_we     (imem_we),
        .imem_waddr  (imem_waddr),
        .imem_wdata  (imem_wdata),
        .fetch_fire  (fetch_fire),
        .fetch_instr (fetch_instr),
        .halted      (halted)
    );

    exec_core exec_core_i (
        .clk         (clk),
        .rst         (rst),
        .fetch_fire  (fetch_fire),
        .fetch_instr (fetch_instr),
        .wb_result   (wb_result)
    );

    // tracker sees the same fire strobe as the core
    trace_unit #(
        .TRACE_DEPTH (TRACE_DEPTH)
    ) trace_unit_i (
        .clk              (clk),
        .rst              (rst),
        .run              (run),
        .fetch_fire       (fetch_fire),
        .wb_result        (wb_result),
        .trace_idx        (trace_idx),
        .trace_fetch_cyc  (trace_fetch_cyc),
        .trace_retire_cyc (trace_retire_cyc),
        .trace_result     (trace_result),
        .retired_count    (retired_count)
    );

endmodule

// File: src/trace_unit.sv
`timescale 1ns/1ps

module trace_unit #(
    parameter int TRACE_DEPTH = 64
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        run,
    input  logic                        fetch_fire,
    input  logic [pipe_pkg::DATA_W-1:0] wb_result,
    input  logic [pipe_pkg::IDX_W-1:0]  trace_idx,
    output logic [pipe_pkg::CYC_W-1:0]  trace_fetch_cyc,
    output logic [pipe_pkg::CYC_W-1:0]  trace_retire_cyc,
    output logic [pipe_pkg::DATA_W-1:0] trace_result,
    output logic [7:0]                  retired_count
);
    import pipe_pkg::*;

    localparam int SEQ_W = $clog2(TRACE_DEPTH);

    // cycle counter, 0 in the first running cycle
    logic [CYC_W-1:0]  cyc;

    // sequence number of the next fetch, then one copy per later stage
    logic [SEQ_W-1:0]  fetch_seq;
    logic [SEQ_W-1:0]  seq_d;
    logic [SEQ_W-1:0]  seq_e;
    logic [SEQ_W-1:0]  seq_m;
    logic [SEQ_W-1:0]  seq_w;
    logic              v_d;
    logic              v_e;
    logic              v_m;
    logic              v_w;

    // trace buffer, one entry per sequence number
    logic [CYC_W-1:0]  fetch_cyc_mem  [TRACE_DEPTH];
    logic [CYC_W-1:0]  retire_cyc_mem [TRACE_DEPTH];
    logic [DATA_W-1:0] result_mem     [TRACE_DEPTH];

    always_ff @(posedge clk) begin
        if (rst || !run) begin
            cyc <= '0;
        end else begin
            cyc <= cyc + 1'b1;
        end
    end

    ////////////////////
    // stage tracking
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_seq     <= '0;
            retired_count <= '0;
            v_d           <= 1'b0;
            v_e           <= 1'b0;
            v_m           <= 1'b0;
            v_w           <= 1'b0;
        end else begin
            if (!run) begin
                fetch_seq <= '0;
            end else if (fetch_fire) begin
                fetch_seq <= fetch_seq + 1'b1;
            end
            if (!run) begin
                retired_count <= '0;
            end else if (v_w) begin
                retired_count <= retired_count + 1'b1;
            end
            // same four steps as the core valid bits
            v_d <= fetch_fire;
            v_e <= v_d;
            v_m <= v_e;
            v_w <= v_m;
        end
    end

    always_ff @(posedge clk) begin
        seq_d <= fetch_seq;
        seq_e <= seq_d;
        seq_m <= seq_e;
        seq_w <= seq_m;
    end

    ////////////////////
    // trace buffer
    ////////////////////

    // fetch stamp on issue, retire stamp and result at writeback
    always_ff @(posedge clk) begin
        if (fetch_fire && 32'(fetch_seq) < TRACE_DEPTH) begin
            fetch_cyc_mem[fetch_seq] <= cyc;
        end
        if (v_w && 32'(seq_w) < TRACE_DEPTH) begin
            retire_cyc_mem[seq_w] <= cyc;
            result_mem[seq_w]     <= wb_result;
        end
    end

    // host readout, indices past the depth read 0
    always_comb begin
        trace_fetch_cyc  = '0;
        trace_retire_cyc = '0;
        trace_result     = '0;
        if (32'(trace_idx) < TRACE_DEPTH) begin
            trace_fetch_cyc  = fetch_cyc_mem[trace_idx[SEQ_W-1:0]];
            trace_retire_cyc = retire_cyc_mem[trace_idx[SEQ_W-1:0]];
            trace_result     = result_mem[trace_idx[SEQ_W-1:0]];
        end
    end

endmodule

// File: src/wb_host_regs.sv
`timescale 1ns/1ps

module wb_host_regs (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         wb_cyc,
    input  logic                         wb_stb,
    input  logic                         wb_we,
    input  logic [pipe_pkg::ADR_W-1:0]   wb_adr,
    input  logic [31:0]                  wb_dat_w,
    output logic [31:0]                  wb_dat_r,
    output logic                         wb_ack,
    input  logic                         halted,
    input  logic [7:0]                   retired_count,
    input  logic [pipe_pkg::CYC_W-1:0]   trace_fetch_cyc,
    input  logic [pipe_pkg::CYC_W-1:0]   trace_retire_cyc,
    input  logic [pipe_pkg::DATA_W-1:0]  trace_result,
    output logic                         imem_we,
    output logic [pipe_pkg::IDX_W-1:0]   imem_waddr,
    output logic [pipe_pkg::INSTR_W-1:0] imem_wdata,
    output logic                         run,
    output logic                         hold,
    output logic [pipe_pkg::IDX_W-1:0]   trace_idx
);
    import pipe_pkg::*;

    // access cycle, first cycle of a strobe before the ack
    logic                   acc;
    // upper address bits pick the region
    logic [ADR_W-IDX_W-1:0] region;
    logic [31:0]            rd_data;

    assign acc    = wb_cyc && wb_stb && !wb_ack;
    assign region = wb_adr[ADR_W-1:IDX_W];

    // ack one cycle after the strobe, for one cycle only
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= acc;
        end
    end

    // control register, run in bit 0 and hold in bit 1
    always_ff @(posedge clk) begin
        if (rst) begin
            run  <= 1'b0;
            hold <= 1'b0;
        end else if (acc && wb_we && wb_adr == ADR_CTRL) begin
            run  <= wb_dat_w[0];
            hold <= wb_dat_w[1];
        end
    end

    ////////////////////
    // program loading
    ////////////////////

    // strobe lands on the same edge that raises the ack
    assign imem_we    = acc && wb_we && region == ADR_IMEM_BASE[ADR_W-1:IDX_W];
    assign imem_waddr = wb_adr[IDX_W-1:0];
    assign imem_wdata = wb_dat_w[INSTR_W-1:0];

    ////////////////////
    // read path
    ////////////////////

    // trace entry selected by the low address bits in both trace regions
    assign trace_idx = wb_adr[IDX_W-1:0];

    always_comb begin
        rd_data = '0;
        if (wb_adr == ADR_CTRL) begin
            rd_data = {30'd0, hold, run};
        end else if (wb_adr == ADR_STATUS) begin
            rd_data = {8'd0, retired_count, 15'd0, halted};
        end else if (region == ADR_TRACE_CYC_BASE[ADR_W-1:IDX_W]) begin
            // retire stamp high, fetch stamp low
            rd_data = {trace_retire_cyc, trace_fetch_cyc};
        end else if (region == ADR_TRACE_RES_BASE[ADR_W-1:IDX_W]) begin
            rd_data = 32'(trace_result);
        end
        // imem region is write only and falls through as 0
    end

    // read data registered alongside the ack
    always_ff @(posedge clk) begin
        if (acc) begin
            wb_dat_r <= rd_data;
        end
    end

endmodule

// File: tb/pipe_trace_checker.sv
`timescale 1ns/1ps

module pipe_trace_checker (
    input logic       clk,
    input logic       rst,
    input logic       wb_cyc,
    input logic       wb_stb,
    input logic       wb_ack,
    input logic       run,
    input logic [7:0] retired_count
);
    // failed assertion count
    int fail_count = 0;

    // ack only inside an active bus cycle
    ack_inside_cycle: assert property (
        @(posedge clk) disable iff (rst) wb_ack |-> (wb_cyc && wb_stb)
    ) else begin
        $error("wb_ack high without wb_cyc and wb_stb");
        fail_count++;
    end

    // single cycle ack
    ack_single_cycle: assert property (
        @(posedge clk) disable iff (rst) wb_ack |=> !wb_ack
    ) else begin
        $error("wb_ack high for two cycles in a row");
        fail_count++;
    end

    // stopped pipeline, retire counter frozen once run has been low a full cycle
    retired_idle: assert property (
        @(posedge clk) disable iff (rst) (!run && !$past(run)) |=> $stable(retired_count)
    ) else begin
        $error("retired_count moved while run was low");
        fail_count++;
    end

endmodule

bind pipe_trace_top pipe_trace_checker pipe_trace_checker_i (
    .clk           (clk),
    .rst           (rst),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_ack        (wb_ack),
    .run           (run),
    .retired_count (retired_count)
);

// File: tb/pipe_trace_tb.sv
`timescale 1ns/1ps

module pipe_trace_tb;
    import pipe_pkg::*;

    localparam int IMEM_DEPTH  = 64;
    localparam int TRACE_DEPTH = 64;
    localparam int LOG_DEPTH   = 4096;
    // program words over the three runs
    localparam int PROG_WORDS  = 64 + 24 + 44;
    localparam int HOLD_ROUNDS = 8;
    // two control writes plus the random gaps per round
    localparam int HOLD_CYCLES = HOLD_ROUNDS * 16;
    // loads, polls and trace reads, at most 4 cycles each
    localparam int WB_ACCESSES = 1000;
    localparam int TIMEOUT_CYCLES = 4 * (PROG_WORDS + HOLD_CYCLES + 4 * WB_ACCESSES);

    logic             clk;
    logic             rst;
    logic             wb_cyc;
    logic             wb_stb;
    logic             wb_we;
    logic [ADR_W-1:0] wb_adr;
    logic [31:0]      wb_dat_w;
    logic [31:0]      wb_dat_r;
    logic             wb_ack;

    logic [31:0]        lcg_state;
    logic [INSTR_W-1:0] prog       [IMEM_DEPTH];
    logic [DATA_W-1:0]  exp_res    [IMEM_DEPTH];
    logic [CYC_W-1:0]   got_fetch  [TRACE_DEPTH];
    logic [CYC_W-1:0]   got_retire [TRACE_DEPTH];
    logic [DATA_W-1:0]  got_res    [TRACE_DEPTH];
    logic [CYC_W-1:0]   pre_fetch  [TRACE_DEPTH];
    logic [CYC_W-1:0]   pre_retire [TRACE_DEPTH];
    logic [DATA_W-1:0]  pre_res    [TRACE_DEPTH];
    // hold state of every running cycle, index is the DUT cycle counter
    logic               hold_log   [LOG_DEPTH];
    int                 log_len;
    logic               ctl_run;
    logic               ctl_hold;
    int                 n_fetched;
    bit                 check_prefill;
    bit                 cmp_req;
    int                 value_errs;
    int                 other_errs;
    int                 ack_wait;
    int                 cycle_count = 0;

    pipe_trace_top #(
        .IMEM_DEPTH  (IMEM_DEPTH),
        .TRACE_DEPTH (TRACE_DEPTH)
    ) pipe_trace_top_i (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    ////////////////////
    // stimulus helpers
    ////////////////////

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {8'd0, lcg_state[31:8]};
    endfunction

    function automatic logic [INSTR_W-1:0] alu_word(logic [3:0] op, int rd, int rs1, int rs2);
        return {op, 3'(rd), 3'(rs1), 3'(rs2), 3'b000};
    endfunction

    function automatic logic [INSTR_W-1:0] ldi_word(int rd, logic [7:0] imm);
        return {4'(OP_LDI), 3'(rd), 1'b0, imm};
    endfunction

    // any opcode but halt, an undefined code included
    function automatic logic [INSTR_W-1:0] random_word();
        logic [31:0] r;
        logic [3:0]  op;
        r = next_rand();
        case (r[14:12])
            3'd0:       op = OP_NOP;
            3'd1:       op = OP_LDI;
            3'd2, 3'd6: op = OP_ADD;
            3'd3:       op = OP_SUB;
            3'd4:       op = OP_AND;
            3'd5:       op = OP_XOR;
            default:    op = 4'h9;
        endcase
        return {op, r[11:0]};
    endfunction

    // plain sequential ISA, returns the number of instructions issued
    function automatic int model_program(input int len);
        logic [DATA_W-1:0] regs [NUM_REGS];
        logic [3:0]        op;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] res;
        for (int r = 0; r < NUM_REGS; r++) begin
            regs[r] = '0;
        end
        for (int i = 0; i < len; i++) begin
            op = prog[i][15:12];
            a  = regs[prog[i][8:6]];
            b  = regs[prog[i][5:3]];
            case (op)
                OP_LDI:  res = {8'd0, prog[i][7:0]};
                OP_ADD:  res = a + b;
                OP_SUB:  res = a - b;
                OP_AND:  res = a & b;
                OP_XOR:  res = a ^ b;
                default: res = '0;
            endcase
            exp_res[i] = res;
            if (op inside {OP_LDI, OP_ADD, OP_SUB, OP_AND, OP_XOR}) begin
                regs[prog[i][11:9]] = res;
            end
            if (op == OP_HALT) begin
                return i + 1;
            end
        end
        return len;
    endfunction

    ////////////////////
    // wishbone master
    ////////////////////

    // one classic cycle, ack and data sampled at the falling edge
    task automatic wb_access(input logic we, input logic [ADR_W-1:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdata;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!wb_ack && waited < 16);
        ack_wait = waited;
        rdata    = wb_dat_r;
        assert (wb_ack) else begin
            other_errs++;
            $display("no acknowledge from the DUT at address %h", adr);
        end
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_write(input logic [ADR_W-1:0] adr, input logic [31:0] data);
        logic [31:0] discard;
        wb_access(1'b1, adr, data, discard);
    endtask

    task automatic wb_read(input logic [ADR_W-1:0] adr, output logic [31:0] data);
        wb_access(1'b0, adr, 32'd0, data);
    endtask

    task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            value_errs++;
            $display("ERR %0t: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    // strobe edge to ack cycle, two cycles
    task automatic check_handshake(input string what);
        assert (ack_wait == 2) else begin
            value_errs++;
            $display("ERR %0t: %s acked after %0d cycles, expected 2", $time, what, ack_wait);
        end
    endtask

    ////////////////////
    // program runs
    ////////////////////

    // hold raised and dropped through CTRL with random spacing
    task automatic toggle_hold(input int rounds);
        int gap;
        for (int r = 0; r < rounds; r++) begin
            wb_write(ADR_CTRL, 32'd3);
            gap = next_rand() % 5;
            repeat (gap) @(posedge clk);
            wb_write(ADR_CTRL, 32'd1);
            gap = next_rand() % 4;
            repeat (gap) @(posedge clk);
        end
    endtask

    task automatic read_trace();
        logic [31:0] d;
        for (int i = 0; i < TRACE_DEPTH; i++) begin
            wb_read(ADR_TRACE_CYC_BASE + ADR_W'(i), d);
            got_fetch[i]  = d[15:0];
            got_retire[i] = d[31:16];
            wb_read(ADR_TRACE_RES_BASE + ADR_W'(i), d);
            got_res[i] = d[15:0];
        end
    endtask

    task automatic run_program(input int len, input bit with_hold, input bit keep_check);
        int          n;
        logic        halt_exp;
        logic [31:0] status;
        for (int i = 0; i < len; i++) begin
            wb_write(ADR_IMEM_BASE + ADR_W'(i), 32'(prog[i]));
        end
        n        = model_program(len);
        halt_exp = (prog[n-1][15:12] == OP_HALT);
        wb_write(ADR_CTRL, 32'd1);
        if (with_hold) begin
            toggle_hold(HOLD_ROUNDS);
        end
        // poll until everything issued has retired
        status = '0;
        while (status[23:16] != 8'(n)) begin
            wb_read(ADR_STATUS, status);
        end
        // nothing past the halt may retire afterwards
        repeat (8) @(posedge clk);
        wb_read(ADR_STATUS, status);
        check_word("STATUS after the run", status, {8'd0, 8'(n), 15'd0, halt_exp});
        wb_write(ADR_CTRL, 32'd0);
        read_trace();
        n_fetched     = n;
        check_prefill = keep_check;
        cmp_req       = 1'b1;
        wait (!cmp_req);
    endtask

    ////////////////////
    // reference tracking
    ////////////////////

    // control register copy, a new value holds from the ack cycle on
    always @(negedge clk) begin
        if (rst) begin
            ctl_run  = 1'b0;
            ctl_hold = 1'b0;
            log_len  = 0;
        end else begin
            if (wb_ack && wb_we && wb_adr == ADR_CTRL) begin
                if (wb_dat_w[0] && !ctl_run) begin
                    log_len = 0;
                end
                ctl_run  = wb_dat_w[0];
                ctl_hold = wb_dat_w[1];
            end
            if (ctl_run && log_len < LOG_DEPTH) begin
                hold_log[log_len] = ctl_hold;
                log_len++;
            end
        end
    end

    // trace compare, entry i is fetched in the i-th cycle without hold
    always begin
        int c;
        wait (cmp_req);
        c = 0;
        for (int i = 0; i < TRACE_DEPTH; i++) begin
            if (i < n_fetched) begin
                while (c < log_len && hold_log[c]) begin
                    c++;
                end
                assert (got_res[i] === exp_res[i]) else begin
                    value_errs++;
                    $display("ERR %0t: entry %0d result %h, expected %h",
                             $time, i, got_res[i], exp_res[i]);
                end
                assert (got_fetch[i] === CYC_W'(c)) else begin
                    value_errs++;
                    $display("ERR %0t: entry %0d fetch cycle %0d, expected %0d",
                             $time, i, got_fetch[i], c);
                end
                // four stages after the fetch cycle
                assert (got_retire[i] === CYC_W'(c + 4)) else begin
                    value_errs++;
                    $display("ERR %0t: entry %0d retire cycle %0d, expected %0d",
                             $time, i, got_retire[i], c + 4);
                end
                if (i > 0) begin
                    assert (got_fetch[i] > got_fetch[i-1]) else begin
                        value_errs++;
                        $display("ERR %0t: entry %0d fetched no later than entry %0d",
                                 $time, i, i - 1);
                    end
                end
                c++;
            end else if (check_prefill) begin
                // entries past the halt keep the prefill contents
                assert (got_fetch[i] === pre_fetch[i] && got_retire[i] === pre_retire[i]
                        && got_res[i] === pre_res[i]) else begin
                    value_errs++;
                    $display("ERR %0t: entry %0d past the halt was overwritten", $time, i);
                end
            end
        end
        cmp_req = 1'b0;
    end

    ////////////////////
    // test sequence
    ////////////////////

    initial begin
        logic [31:0] d;
        clk           = 1'b0;
        rst           = 1'b1;
        wb_cyc        = 1'b0;
        wb_stb        = 1'b0;
        wb_we         = 1'b0;
        wb_adr        = '0;
        wb_dat_w      = '0;
        lcg_state     = 32'hf10a278d;
        value_errs    = 0;
        other_errs    = 0;
        cmp_req       = 1'b0;
        check_prefill = 1'b0;
        n_fetched     = 0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // registers clear after reset, unmapped and imem reads give 0
        wb_read(ADR_STATUS, d);
        check_word("STATUS after reset", d, 32'd0);
        check_handshake("STATUS read");
        wb_read(ADR_CTRL, d);
        check_word("CTRL after reset", d, 32'd0);
        check_handshake("CTRL read");
        wb_read(9'h042, d);
        check_word("unmapped 0x042", d, 32'd0);
        wb_read(9'h100, d);
        check_word("unmapped 0x100", d, 32'd0);
        check_handshake("unmapped read");
        wb_read(9'h005, d);
        check_word("imem word 5", d, 32'd0);

        // prefill, 64 words without halt fill every trace entry
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            prog[i] = (i < NUM_REGS) ? ldi_word(i, 8'(next_rand())) : random_word();
        end
        run_program(IMEM_DEPTH, 1'b0, 1'b0);
        for (int i = 0; i < TRACE_DEPTH; i++) begin
            pre_fetch[i]  = got_fetch[i];
            pre_retire[i] = got_retire[i];
            pre_res[i]    = got_res[i];
        end

        // directed chain, operands from execute, memory, writeback and rf
        for (int i = 0; i < NUM_REGS; i++) begin
            prog[i] = ldi_word(i, 8'(8'h11 * (i + 1)));
        end
        prog[8]  = alu_word(OP_ADD, 3, 1, 2);
        prog[9]  = alu_word(OP_SUB, 4, 3, 1);
        prog[10] = alu_word(OP_AND, 5, 4, 3);
        prog[11] = alu_word(OP_XOR, 6, 5, 3);
        prog[12] = alu_word(OP_ADD, 0, 6, 4);
        prog[13] = alu_word(OP_SUB, 1, 0, 0);
        prog[14] = alu_word(OP_XOR, 2, 6, 1);
        prog[15] = alu_word(OP_ADD, 7, 7, 7);
        prog[16] = ldi_word(3, 8'hff);
        prog[17] = alu_word(OP_ADD, 3, 3, 3);
        prog[18] = alu_word(OP_SUB, 3, 3, 2);
        prog[19] = alu_word(OP_HALT, 0, 0, 0);
        // words past the halt must never issue
        for (int i = 20; i < 24; i++) begin
            prog[i] = ldi_word(i % NUM_REGS, 8'haa);
        end
        run_program(24, 1'b0, 1'b1);

        // random program with hold toggled during the run
        for (int i = 0; i < 44; i++) begin
            if (i < NUM_REGS) begin
                prog[i] = ldi_word(i, 8'(next_rand()));
            end else if (i == 39) begin
                prog[i] = alu_word(OP_HALT, 0, 0, 0);
            end else begin
                prog[i] = random_word();
            end
        end
        run_program(44, 1'b1, 1'b1);

        $display("errors: %0d value, %0d handshake, %0d assertion", value_errs, other_errs,
                 pipe_trace_top_i.pipe_trace_checker_i.fail_count);
        if (value_errs + other_errs + pipe_trace_top_i.pipe_trace_checker_i.fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
